/* build.f */
hdl/cpu_pkg.sv
hdl/inst_decoder.sv
hdl/regfile.sv
hdl/alu.sv
hdl/multicycle_ctrl.sv
hdl/cpu_top.sv
tests/tb_clock_gen.sv
tests/sram_model.sv
tests/cpu_tb.sv

/* tests/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb;

    localparam cpu_pkg::word_t RESET_PC   = 32'h1c000000;
    localparam int             PROG_LEN   = 32;
    localparam int             MEM_WORDS  = 64;
    localparam int             MAX_CYCLES = 10 + 5 * PROG_LEN + 50;

    // One program word and the register write it must trace.
    typedef struct packed {
        cpu_pkg::word_t     inst;
        logic               traced;
        cpu_pkg::reg_addr_t wnum;
        cpu_pkg::word_t     wdata;
    } row_t;

    logic               clk;
    logic               reset;
    cpu_pkg::word_t     inst_sram_addr, inst_sram_rdata, data_sram_rdata;
    cpu_pkg::data_req_t data_req;
    cpu_pkg::trace_t    debug_wb;
    row_t               rows [PROG_LEN];
    int                 cycles;
    int                 store_count = 0;
    logic               seen_write  = 1'b0;

    tb_clock_gen #(.RESET_CYCLES(10)) clock_gen (.clk(clk), .reset(reset));

    sram_model #(.RESET_PC(RESET_PC), .WORDS(MEM_WORDS)) mem (
        .clk        (clk),
        .inst_addr  (inst_sram_addr),
        .inst_rdata (inst_sram_rdata),
        .data_req   (data_req),
        .data_rdata (data_sram_rdata)
    );

    cpu_top #(.RESET_PC(RESET_PC)) dut (
        .clk             (clk),
        .reset           (reset),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .data_req        (data_req),
        .data_sram_rdata (data_sram_rdata),
        .debug_wb        (debug_wb)
    );

    // ----------------------------------------
    // Program and expected trace
    // ----------------------------------------
    task automatic fill_rows();
        rows[0]  = {32'h02801401, 1'b1, 5'd1,  32'h00000005};  // addi.w r1, r0, 5.
        rows[1]  = {32'h02bff402, 1'b1, 5'd2,  32'hfffffffd};  // addi.w r2, r0, -3.
        rows[2]  = {32'h142468a3, 1'b1, 5'd3,  32'h12345000};  // lu12i.w r3, 0x12345.
        rows[3]  = {32'h00100824, 1'b1, 5'd4,  32'h00000002};  // add.w r4, r1, r2.
        rows[4]  = {32'h00110825, 1'b1, 5'd5,  32'h00000008};  // sub.w r5, r1, r2.
        rows[5]  = {32'h00120446, 1'b1, 5'd6,  32'h00000001};  // slt r6, r2, r1.
        rows[6]  = {32'h00128447, 1'b1, 5'd7,  32'h00000000};  // sltu r7, r2, r1.
        rows[7]  = {32'h00150469, 1'b1, 5'd9,  32'h12345005};  // or r9, r3, r1.
        rows[8]  = {32'h0014082a, 1'b1, 5'd10, 32'h00000002};  // nor r10, r1, r2.
        rows[9]  = {32'h0015886b, 1'b1, 5'd11, 32'hedcbaffd};  // xor r11, r3, r2.
        rows[10] = {32'h0014ad28, 1'b1, 5'd8,  32'h00000005};  // and r8, r9, r11.
        rows[11] = {32'h0040904c, 1'b1, 5'd12, 32'hffffffd0};  // slli.w r12, r2, 4.
        rows[12] = {32'h0044904d, 1'b1, 5'd13, 32'h0fffffff};  // srli.w r13, r2, 4.
        rows[13] = {32'h0048844e, 1'b1, 5'd14, 32'hfffffffe};  // srai.w r14, r2, 1.
        rows[14] = {32'h0281000f, 1'b1, 5'd15, 32'h00000040};  // addi.w r15, r0, 0x40.
        rows[15] = {32'h298021e3, 1'b0, 5'd0,  32'h00000000};  // st.w r3, r15, 8.
        rows[16] = {32'h288021f0, 1'b1, 5'd16, 32'h12345000};  // ld.w r16, r15, 8.
        rows[17] = {32'h58000c22, 1'b0, 5'd0,  32'h00000000};  // beq r1, r2 not taken.
        rows[18] = {32'h02801c11, 1'b1, 5'd17, 32'h00000007};  // addi.w r17, r0, 7.
        rows[19] = {32'h58000821, 1'b0, 5'd0,  32'h00000000};  // beq r1, r1 to 21.
        rows[20] = {32'h02800412, 1'b0, 5'd0,  32'h00000000};  // Skipped.
        rows[21] = {32'h5c000822, 1'b0, 5'd0,  32'h00000000};  // bne r1, r2 to 23.
        rows[22] = {32'h02800812, 1'b0, 5'd0,  32'h00000000};  // Skipped.
        rows[23] = {32'h50000800, 1'b0, 5'd0,  32'h00000000};  // b to 25.
        rows[24] = {32'h02800c12, 1'b0, 5'd0,  32'h00000000};  // Skipped.
        rows[25] = {32'h54000800, 1'b1, 5'd1,  32'h1c000068};  // bl to 27.
        rows[26] = {32'h02801012, 1'b0, 5'd0,  32'h00000000};  // Skipped.
        rows[27] = {32'h4c001034, 1'b1, 5'd20, 32'h1c000070};  // jirl r20, r1, 4 to 30.
        rows[28] = {32'h02801412, 1'b0, 5'd0,  32'h00000000};  // Skipped.
        rows[29] = {32'h02801812, 1'b0, 5'd0,  32'h00000000};  // Skipped.
        rows[30] = {32'h02802400, 1'b1, 5'd0,  32'h00000009};  // addi.w r0, r0, 9.
        rows[31] = {32'h00104415, 1'b1, 5'd21, 32'h00000007};  // add.w r21, r0, r17.
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_word(input string name, input cpu_pkg::word_t got,
                                input cpu_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_reg_addr(input string name, input cpu_pkg::reg_addr_t got,
                                    input cpu_pkg::reg_addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_write(input int index);
        cpu_pkg::word_t pc;
        pc = RESET_PC + 32'(4 * index);
        while (debug_wb.rf_we !== 1'b1) begin
            if (debug_wb.rf_we !== 1'b0) begin
                abort_run("Register write strobe went unknown");
            end
            if (!seen_write && data_req.we !== 1'b0) begin
                abort_run("Store strobe seen before the first register write");
            end
            @(negedge clk);
        end
        seen_write = 1'b1;
        compare_word("debug_wb.pc", debug_wb.pc, pc);
        compare_word("inst_sram_addr", inst_sram_addr, pc);
        compare_reg_addr("debug_wb.wnum", debug_wb.wnum, rows[index].wnum);
        compare_word("debug_wb.wdata", debug_wb.wdata, rows[index].wdata);
        @(negedge clk);
        if (debug_wb.rf_we !== 1'b0) begin
            abort_run("Register write strobe held for more than one cycle");
        end
    endtask

    always @(negedge clk) begin
        if (!reset && data_req.we === 1'b1) begin
            store_count++;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        abort_run($sformatf("Timeout: trace still incomplete after %0d cycles", cycles));
    end

    initial begin
        fill_rows();
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (i < PROG_LEN)
                mem.load_word(i, rows[i].inst);
            else
                mem.load_word(i, 32'd0);  // Runs as a no-op.
        end
        wait (reset == 1'b0);
        @(negedge clk);
        if (debug_wb.rf_we !== 1'b0 || data_req.we !== 1'b0) begin
            abort_run("Write strobes not low after reset");
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            if (rows[i].traced) begin
                check_write(i);
            end
        end
        compare_word("data memory 0x48", mem.data_word(32'h48), 32'h12345000);  // r15 + 8.
        if (store_count != 1) begin
            abort_run($sformatf("Expected one store cycle, saw %0d", store_count));
        end
        $display("Verification passed");
        $finish;
    end

endmodule

/* tests/sram_model.sv */
`timescale 1ns/10ps

module sram_model #(
    parameter cpu_pkg::word_t RESET_PC = 32'h1c000000,
    parameter int             WORDS    = 64
) (
    input  logic               clk,
    input  cpu_pkg::word_t     inst_addr,
    output cpu_pkg::word_t     inst_rdata,
    input  cpu_pkg::data_req_t data_req,
    output cpu_pkg::word_t     data_rdata
);

    cpu_pkg::word_t imem [WORDS];
    cpu_pkg::word_t dmem [WORDS];
    cpu_pkg::word_t imem_offs;

    assign imem_offs  = inst_addr - RESET_PC;
    assign inst_rdata = (imem_offs < 4 * WORDS) ? imem[imem_offs[31:2]] : 32'd0;
    assign data_rdata = dmem[data_req.addr[31:2] % WORDS];  // Wraps on the low bits.

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            dmem[i] <= 32'd0;
        end
    end

    always @(posedge clk) begin
        if (data_req.we === 1'b1) begin
            dmem[data_req.addr[31:2] % WORDS] <= data_req.wdata;
        end
    end

    task automatic load_word(input int index, input cpu_pkg::word_t word);
        imem[index] = word;
    endtask

    function automatic cpu_pkg::word_t data_word(input cpu_pkg::word_t addr);
        return dmem[addr[31:2] % WORDS];
    endfunction

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0;  // Just after an edge.
    end

endmodule

/* hdl/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = 32'h1c000000
) (
    input  logic               clk,
    input  logic               reset,
    output cpu_pkg::word_t     inst_sram_addr,
    input  cpu_pkg::word_t     inst_sram_rdata,
    output cpu_pkg::data_req_t data_req,
    input  cpu_pkg::word_t     data_sram_rdata,
    output cpu_pkg::trace_t    debug_wb
);

    cpu_pkg::word_t     inst;
    cpu_pkg::decode_t   dec;
    cpu_pkg::word_t     rdata1, rdata2;
    cpu_pkg::alu_op_e   alu_op;
    cpu_pkg::word_t     alu_src1, alu_src2, alu_result;
    logic               rf_we;
    cpu_pkg::reg_addr_t rf_waddr;
    cpu_pkg::word_t     rf_wdata;

    inst_decoder u_decoder (
        .inst (inst),
        .dec  (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec.raddr1),
        .rdata1 (rdata1),
        .raddr2 (dec.raddr2),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    alu u_alu (
        .op     (alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    multicycle_ctrl #(
        .RESET_PC (RESET_PC)
    ) u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .inst_addr  (inst_sram_addr),
        .inst_rdata (inst_sram_rdata),
        .inst       (inst),
        .dec        (dec),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .alu_op     (alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result),
        .data_req   (data_req),
        .data_rdata (data_sram_rdata),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .trace      (debug_wb)
    );

endmodule

/* hdl/multicycle_ctrl.sv */
`timescale 1ns/10ps

module multicycle_ctrl #(
    parameter cpu_pkg::word_t RESET_PC = 32'h1c000000
) (
    input  logic                 clk,
    input  logic                 reset,
    output cpu_pkg::word_t       inst_addr,
    input  cpu_pkg::word_t       inst_rdata,
    output cpu_pkg::word_t       inst,
    input  cpu_pkg::decode_t     dec,
    input  cpu_pkg::word_t       rdata1,
    input  cpu_pkg::word_t       rdata2,
    output cpu_pkg::alu_op_e     alu_op,
    output cpu_pkg::word_t       alu_src1,
    output cpu_pkg::word_t       alu_src2,
    input  cpu_pkg::word_t       alu_result,
    output cpu_pkg::data_req_t   data_req,
    input  cpu_pkg::word_t       data_rdata,
    output logic                 rf_we,
    output cpu_pkg::reg_addr_t   rf_waddr,
    output cpu_pkg::word_t       rf_wdata,
    output cpu_pkg::trace_t      trace
);

    typedef enum logic [2:0] {S_FETCH, S_DECODE, S_EXE, S_MEM, S_WB} state_e;

    state_e           state, next_state;
    cpu_pkg::word_t   pc, pc_plus4, pc_next;
    cpu_pkg::word_t   ir;
    cpu_pkg::decode_t dec_q;
    cpu_pkg::word_t   rj_q, rkd_q, alu_q, mem_q;
    logic             br_taken, br_taken_q;
    cpu_pkg::word_t   br_target, br_target_q;
    logic             req_we;
    cpu_pkg::word_t   req_addr, req_wdata;

    assign inst_addr = pc;
    assign inst      = ir;
    assign pc_plus4  = pc + 32'd4;

    // ----------------------------------------
    // Branch resolution in DECODE
    // ----------------------------------------
    always_comb begin
        case (dec.br_kind)
            cpu_pkg::BR_ALWAYS, cpu_pkg::BR_JIRL: br_taken = 1'b1;
            cpu_pkg::BR_EQ:                       br_taken = rdata1 == rdata2;
            cpu_pkg::BR_NE:                       br_taken = rdata1 != rdata2;
            default:                              br_taken = 1'b0;
        endcase
        br_target = ((dec.br_kind == cpu_pkg::BR_JIRL) ? rdata1 : pc) + dec.br_offs;
    end

    always_comb begin
        case (state)
            S_FETCH:  next_state = S_DECODE;
            S_DECODE: next_state = (dec.gr_we || dec.mem_we) ? S_EXE : S_FETCH;
            S_EXE:    next_state = (dec_q.mem_we || dec_q.res_from_mem) ? S_MEM : S_WB;
            S_MEM:    next_state = dec_q.res_from_mem ? S_WB : S_FETCH;
            default:  next_state = S_FETCH;
        endcase
    end

    // Short branches resolve and retire in the same cycle.
    assign pc_next = (state == S_DECODE) ? (br_taken ? br_target : pc_plus4)
                                         : (br_taken_q ? br_target_q : pc_plus4);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= S_FETCH;
            pc     <= RESET_PC;
            req_we <= 1'b0;
        end else begin
            state  <= next_state;
            req_we <= (state == S_EXE) && dec_q.mem_we;  // One MEMORY cycle.
            if (state != S_FETCH && next_state == S_FETCH) begin
                pc <= pc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH) begin
            ir <= inst_rdata;
        end
        if (state == S_DECODE) begin
            dec_q       <= dec;
            rj_q        <= rdata1;
            rkd_q       <= rdata2;
            br_taken_q  <= br_taken;
            br_target_q <= br_target;
        end
        if (state == S_EXE) begin
            alu_q     <= alu_result;
            req_addr  <= alu_result;
            req_wdata <= rkd_q;
        end
        if (state == S_MEM) begin
            mem_q <= data_rdata;
        end
    end

    // ----------------------------------------
    // Datapath outputs
    // ----------------------------------------
    assign alu_op   = dec_q.alu_op;
    assign alu_src1 = dec_q.src1_is_pc ? pc : rj_q;
    assign alu_src2 = dec_q.src2_is_imm ? dec_q.imm : rkd_q;

    assign data_req = '{we: req_we, addr: req_addr, wdata: req_wdata};

    // Links carry pc + 4 out of the ALU.
    assign rf_we    = state == S_WB;
    assign rf_waddr = dec_q.dest;
    assign rf_wdata = dec_q.res_from_mem ? mem_q : alu_q;

    assign trace = '{pc: pc, rf_we: rf_we, wnum: rf_waddr, wdata: rf_wdata};

    a_store_in_mem: assert property (
        @(posedge clk) disable iff (reset)
        data_req.we |-> (state == S_MEM) ##1 !data_req.we
    ) else $error("store strobe outside MEMORY");

    a_write_in_wb: assert property (
        @(posedge clk) disable iff (reset)
        rf_we |-> dec_q.gr_we && !dec_q.mem_we ##1 !rf_we
    ) else $error("register write outside WRITEBACK");

endmodule

/* hdl/alu.sv */
`timescale 1ns/10ps

module alu (
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::word_t   src1,
    input  cpu_pkg::word_t   src2,
    output cpu_pkg::word_t   result
);

    logic [4:0] shamt;

    assign shamt = src2[4:0];  // Low 5 bits only.

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:  result = src1 + src2;
            cpu_pkg::ALU_SUB:  result = src1 - src2;
            cpu_pkg::ALU_SLT:  result = {31'd0, $signed(src1) < $signed(src2)};
            cpu_pkg::ALU_SLTU: result = {31'd0, src1 < src2};
            cpu_pkg::ALU_AND:  result = src1 & src2;
            cpu_pkg::ALU_NOR:  result = ~(src1 | src2);
            cpu_pkg::ALU_OR:   result = src1 | src2;
            cpu_pkg::ALU_XOR:  result = src1 ^ src2;
            cpu_pkg::ALU_SLL:  result = src1 << shamt;
            cpu_pkg::ALU_SRL:  result = src1 >> shamt;
            cpu_pkg::ALU_SRA:  result = $signed(src1) >>> shamt;
            cpu_pkg::ALU_LUI:  result = src2;  // Immediate already shifted.
            default:           result = 32'd0;
        endcase
    end

endmodule

/* hdl/regfile.sv */
`timescale 1ns/10ps

module regfile (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t raddr1,
    output cpu_pkg::word_t     rdata1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata2,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];  // r0 reads zero.
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

    // Once the core leaves reset the write strobe stays defined.
    a_we_known: assert property (
        @(posedge clk) !$isunknown($past(we)) |-> !$isunknown(we)
    ) else $error("regfile write enable went unknown");

endmodule

/* hdl/inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder (
    input  cpu_pkg::word_t   inst,
    output cpu_pkg::decode_t dec
);

    cpu_pkg::reg_addr_t rd;
    cpu_pkg::reg_addr_t rj;
    cpu_pkg::reg_addr_t rk;
    logic is_add, is_sub, is_slt, is_sltu, is_nor, is_and, is_or, is_xor;
    logic is_slli, is_srli, is_srai, is_addi, is_lu12i;
    logic is_ld, is_st, is_jirl, is_b, is_bl, is_beq, is_bne;
    logic is_reg_op, is_shift, is_link;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    // ----------------------------------------
    // Opcode match
    // ----------------------------------------
    assign is_add   = inst[31:15] == 17'h00020;
    assign is_sub   = inst[31:15] == 17'h00022;
    assign is_slt   = inst[31:15] == 17'h00024;
    assign is_sltu  = inst[31:15] == 17'h00025;
    assign is_nor   = inst[31:15] == 17'h00028;
    assign is_and   = inst[31:15] == 17'h00029;
    assign is_or    = inst[31:15] == 17'h0002a;
    assign is_xor   = inst[31:15] == 17'h0002b;
    assign is_slli  = inst[31:15] == 17'h00081;
    assign is_srli  = inst[31:15] == 17'h00089;
    assign is_srai  = inst[31:15] == 17'h00091;
    assign is_addi  = inst[31:22] == 10'h00a;
    assign is_ld    = inst[31:22] == 10'h0a2;
    assign is_st    = inst[31:22] == 10'h0a6;
    assign is_lu12i = inst[31:25] == 7'h0a;
    assign is_jirl  = inst[31:26] == 6'h13;
    assign is_b     = inst[31:26] == 6'h14;
    assign is_bl    = inst[31:26] == 6'h15;
    assign is_beq   = inst[31:26] == 6'h16;
    assign is_bne   = inst[31:26] == 6'h17;

    assign is_reg_op = is_add | is_sub | is_slt | is_sltu | is_nor | is_and | is_or | is_xor;
    assign is_shift  = is_slli | is_srli | is_srai;
    assign is_link   = is_jirl | is_bl;

    // ----------------------------------------
    // Control fields
    // ----------------------------------------
    always_comb begin
        dec = '0;
        dec.alu_op = cpu_pkg::ALU_ADD;
        if (is_sub)   dec.alu_op = cpu_pkg::ALU_SUB;
        if (is_slt)   dec.alu_op = cpu_pkg::ALU_SLT;
        if (is_sltu)  dec.alu_op = cpu_pkg::ALU_SLTU;
        if (is_and)   dec.alu_op = cpu_pkg::ALU_AND;
        if (is_nor)   dec.alu_op = cpu_pkg::ALU_NOR;
        if (is_or)    dec.alu_op = cpu_pkg::ALU_OR;
        if (is_xor)   dec.alu_op = cpu_pkg::ALU_XOR;
        if (is_slli)  dec.alu_op = cpu_pkg::ALU_SLL;
        if (is_srli)  dec.alu_op = cpu_pkg::ALU_SRL;
        if (is_srai)  dec.alu_op = cpu_pkg::ALU_SRA;
        if (is_lu12i) dec.alu_op = cpu_pkg::ALU_LUI;

        dec.src1_is_pc  = is_link;  // Link value is pc + 4.
        dec.src2_is_imm = is_shift | is_addi | is_ld | is_st | is_lu12i | is_link;

        if (is_link)
            dec.imm = 32'd4;
        else if (is_lu12i)
            dec.imm = {inst[24:5], 12'b0};
        else
            dec.imm = {{20{inst[21]}}, inst[21:10]};

        if (is_b || is_bl)
            dec.br_offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
        else
            dec.br_offs = {{14{inst[25]}}, inst[25:10], 2'b0};

        dec.br_kind = cpu_pkg::BR_NONE;
        if (is_b || is_bl) dec.br_kind = cpu_pkg::BR_ALWAYS;
        if (is_beq)        dec.br_kind = cpu_pkg::BR_EQ;
        if (is_bne)        dec.br_kind = cpu_pkg::BR_NE;
        if (is_jirl)       dec.br_kind = cpu_pkg::BR_JIRL;

        dec.raddr1 = rj;
        dec.raddr2 = (is_beq || is_bne || is_st) ? rd : rk;
        dec.dest   = is_bl ? 5'd1 : rd;

        dec.gr_we        = is_reg_op | is_shift | is_addi | is_lu12i | is_ld | is_link;
        dec.mem_we       = is_st;
        dec.res_from_mem = is_ld;
        dec.illegal      = ~(dec.gr_we | is_st | is_b | is_beq | is_bne);
    end

endmodule

/* hdl/cpu_pkg.sv */
package cpu_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    typedef logic [31:0] word_t;      // Data or address word.
    typedef logic [4:0]  reg_addr_t;  // Register number.

    // ----------------------------------------
    // Encodings
    // ----------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11   // Pass src2.
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE   = 3'd0,
        BR_ALWAYS = 3'd1,  // b and bl.
        BR_EQ     = 3'd2,
        BR_NE     = 3'd3,
        BR_JIRL   = 3'd4
    } br_kind_e;

    // ----------------------------------------
    // Bundles
    // ----------------------------------------
    typedef struct packed {
        alu_op_e   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        word_t     imm;
        word_t     br_offs;
        br_kind_e  br_kind;
        reg_addr_t raddr1;
        reg_addr_t raddr2;
        reg_addr_t dest;
        logic      gr_we;
        logic      mem_we;
        logic      res_from_mem;
        logic      illegal;
    } decode_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } data_req_t;

    typedef struct packed {
        word_t     pc;
        logic      rf_we;
        reg_addr_t wnum;
        word_t     wdata;
    } trace_t;

endpackage
